// ==== cfg_reg_bank.sv ====
// cfg_reg_bank: one channel's configuration words, written by the core config strobe
`default_nettype none
`timescale 1ns/10ps

module cfg_reg_bank #(
    parameter itf_ctr_pkg::bank_code_t bank_code = 2'd0,
    parameter int                      num_words = 10
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_valid,
    input  itf_ctr_pkg::cfg_addr_t cfg_addr,
    input  itf_ctr_pkg::cfg_data_t cfg_data,
    output itf_ctr_pkg::cfg_data_t words [num_words]
);

    import itf_ctr_pkg::*;

    bank_code_t addr_bank;
    word_idx_t  word_idx;
    logic       bank_hit;

    // split config address into bank code and word index
    assign addr_bank = cfg_addr[6:5];
    assign word_idx  = cfg_addr[4:0];

    // strobe aimed at this bank
    assign bank_hit = cfg_valid && (addr_bank == bank_code);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_words; i++) begin
                words[i] <= '0;
            end
        end else if (bank_hit) begin
            // index past num_words matches no word, write dropped
            for (int i = 0; i < num_words; i++) begin
                if (int'(word_idx) == i) begin
                    words[i] <= cfg_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== cmd_dispatch.sv ====
// cmd_dispatch: routes the core command to a channel, muxes the grant, registers cmd_ok
`default_nettype none
`timescale 1ns/10ps

module cmd_dispatch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_req,
    input  itf_ctr_pkg::cmd_code_t cmd_addr,
    input  logic                   core_rd_gnt,
    input  logic                   dma_rd_gnt,
    input  logic                   all_finished,
    output logic                   core_rd_req,
    output logic                   dma_rd_req,
    output logic                   cmd_gnt,
    output logic                   cmd_ok
);

    import itf_ctr_pkg::*;

    // request and grant follow cmd_addr in the same cycle
    always_comb begin
        core_rd_req = 1'b0;
        dma_rd_req  = 1'b0;
        cmd_gnt     = 1'b0;
        case (cmd_addr)
            CMD_CORE_RD: begin
                core_rd_req = cmd_req;
                cmd_gnt     = core_rd_gnt;
            end
            CMD_DMA_RD: begin
                dma_rd_req = cmd_req;
                cmd_gnt    = dma_rd_gnt;
            end
            // finish query answered locally
            CMD_FINISH: cmd_gnt = all_finished;
            // dropped write channels and spare codes
            default: cmd_gnt = 1'b0;
        endcase
    end

    // ok one cycle after grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ok <= 1'b0;
        end else begin
            cmd_ok <= cmd_gnt;
        end
    end

endmodule

`default_nettype wire

// ==== core_rd_field_decode.sv ====
// core_rd_field_decode: core-read fields, target node and local access flag
`default_nettype none
`timescale 1ns/10ps

module core_rd_field_decode #(
    parameter itf_ctr_pkg::node_id_t node_id = 4'd5
) (
    input  itf_ctr_pkg::cfg_data_t  words [itf_ctr_pkg::CORE_RD_WORDS],
    output logic                    cr_mc,
    output logic                    cr_dma_transfer,
    output logic                    cr_pingpong_en,
    output itf_ctr_pkg::node_id_t   cr_target_id,
    output logic                    cr_local_access,
    output itf_ctr_pkg::ram_addr_t  cr_base_addr,
    output itf_ctr_pkg::pp_num_t    cr_pingpong_num,
    output itf_ctr_pkg::ram_addr_t  cr_ping_len,
    output itf_ctr_pkg::ram_addr_t  cr_pong_len
);

    import itf_ctr_pkg::*;

    // 0 absolute, 1 relative to node_id
    logic      addr_mode;
    rel_addr_t rel_offset;
    node_id_t  abs_target;

    assign addr_mode  = words[CR_ADDR_MODE][0];
    assign rel_offset = words[CR_REL_OFFSET][4:0];
    assign abs_target = words[CR_ABS_TARGET][3:0];

    // plain field slices
    assign cr_mc           = words[CR_MC][0];
    assign cr_dma_transfer = words[CR_DMA_TRANSFER][0];
    assign cr_pingpong_en  = words[CR_PP_EN][0];
    assign cr_base_addr    = words[CR_BASE_ADDR];
    assign cr_pingpong_num = words[CR_PP_NUM][10:0];
    assign cr_ping_len     = words[CR_PING_LEN];
    assign cr_pong_len     = words[CR_PONG_LEN];

    // target node, relative mode wraps around 16 nodes
    assign cr_target_id = addr_mode ? rel_node(node_id, rel_offset) : abs_target;

    // own node without multicast reads the local L2 path
    // multicast always goes out through the router, even to itself
    assign cr_local_access = !cr_mc &&
        ((!addr_mode && (abs_target == node_id)) || (addr_mode && (rel_offset[3:0] == 4'd0)));

endmodule

`default_nettype wire

// ==== dma_rd_field_decode.sv ====
// dma_rd_field_decode: dma-read fields and NoC base address composition
`default_nettype none
`timescale 1ns/10ps

module dma_rd_field_decode #(
    parameter itf_ctr_pkg::node_id_t node_id = 4'd5
) (
    input  itf_ctr_pkg::cfg_data_t  words [itf_ctr_pkg::DMA_RD_WORDS],
    output logic                    dr_dma_transfer,
    output logic                    dr_pingpong_en,
    output itf_ctr_pkg::ram_addr_t  dr_ram_base_addr,
    output itf_ctr_pkg::noc_addr_t  dr_noc_base_addr,
    output itf_ctr_pkg::pp_num_t    dr_pingpong_num,
    output itf_ctr_pkg::ram_addr_t  dr_ping_len
);

    import itf_ctr_pkg::*;

    logic      addr_mode;
    rel_addr_t rel_offset;
    noc_high_t high_sel;

    assign addr_mode  = words[DR_ADDR_MODE][0];
    assign rel_offset = words[DR_REL_OFFSET][4:0];

    assign dr_dma_transfer  = words[DR_DMA_TRANSFER][0];
    assign dr_pingpong_en   = words[DR_PP_EN][0];
    assign dr_ram_base_addr = words[DR_RAM_BASE];
    assign dr_pingpong_num  = words[DR_PP_NUM][10:0];
    assign dr_ping_len      = words[DR_PING_LEN];

    // relative mode puts the computed node in the high part
    assign high_sel = addr_mode ? {8'd0, rel_node(node_id, rel_offset)} : words[DR_NOC_HIGH][11:0];

    // 12 bit high part over 13 bit low part
    assign dr_noc_base_addr = {high_sel, words[DR_NOC_LOW]};

endmodule

`default_nettype wire

// ==== dnoc_itf_ctr_sva.sv ====
// command handshake assertions for dnoc_itf_ctr_top, attached by bind
`timescale 1ns/10ps
`default_nettype none

module dnoc_itf_ctr_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   cmd_req,
    input itf_ctr_pkg::cmd_code_t cmd_addr,
    input logic                   cmd_gnt,
    input logic                   cmd_ok,
    input logic                   core_rd_req,
    input logic                   dma_rd_req
);

    import itf_ctr_pkg::*;

    // only one channel asked at a time
    one_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(core_rd_req && dma_rd_req))
        else $error("core and dma read requests high together");

    // channel request only while the core asks
    req_src_a: assert property (@(posedge clk) disable iff (!rst_n)
        (core_rd_req || dma_rd_req) |-> cmd_req)
        else $error("channel request without cmd_req");

    // cmd_ok is the grant delayed by one cycle
    ok_set_a: assert property (@(posedge clk) disable iff (!rst_n) cmd_gnt |=> cmd_ok)
        else $error("cmd_ok missing after grant");
    ok_clr_a: assert property (@(posedge clk) disable iff (!rst_n) !cmd_gnt |=> !cmd_ok)
        else $error("cmd_ok without grant");

    // finish and spare codes never reach a channel
    no_chan_a: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_addr != CMD_CORE_RD && cmd_addr != CMD_DMA_RD) |-> !(core_rd_req || dma_rd_req))
        else $error("channel request on a non-channel code");

endmodule

bind dnoc_itf_ctr_top dnoc_itf_ctr_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_req     (cmd_req),
    .cmd_addr    (cmd_addr),
    .cmd_gnt     (cmd_gnt),
    .cmd_ok      (cmd_ok),
    .core_rd_req (core_rd_req),
    .dma_rd_req  (dma_rd_req)
);

`default_nettype wire

// ==== dnoc_itf_ctr_top.sv ====
// dnoc_itf_ctr_top: register banks, field decoders, command dispatch and finish tracking
`default_nettype none
`timescale 1ns/10ps

module dnoc_itf_ctr_top #(
    parameter itf_ctr_pkg::node_id_t node_id = 4'd5
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_valid,
    input  itf_ctr_pkg::cfg_addr_t  cfg_addr,
    input  itf_ctr_pkg::cfg_data_t  cfg_data,
    input  logic                    cmd_req,
    input  itf_ctr_pkg::cmd_code_t  cmd_addr,
    output logic                    cmd_gnt,
    output logic                    cmd_ok,
    output logic                    core_rd_req,
    input  logic                    core_rd_gnt,
    input  logic                    core_rd_done,
    output logic                    dma_rd_req,
    input  logic                    dma_rd_gnt,
    input  logic                    dma_rd_done,
    output logic                    cr_mc,
    output logic                    cr_dma_transfer,
    output logic                    cr_pingpong_en,
    output itf_ctr_pkg::node_id_t   cr_target_id,
    output logic                    cr_local_access,
    output itf_ctr_pkg::ram_addr_t  cr_base_addr,
    output itf_ctr_pkg::pp_num_t    cr_pingpong_num,
    output itf_ctr_pkg::ram_addr_t  cr_ping_len,
    output itf_ctr_pkg::ram_addr_t  cr_pong_len,
    output logic                    dr_dma_transfer,
    output logic                    dr_pingpong_en,
    output itf_ctr_pkg::ram_addr_t  dr_ram_base_addr,
    output itf_ctr_pkg::noc_addr_t  dr_noc_base_addr,
    output itf_ctr_pkg::pp_num_t    dr_pingpong_num,
    output itf_ctr_pkg::ram_addr_t  dr_ping_len
);

    import itf_ctr_pkg::*;

    cfg_data_t core_rd_words [CORE_RD_WORDS];
    cfg_data_t dma_rd_words  [DMA_RD_WORDS];
    logic      all_finished;

    // both banks share the config strobe, bank code picks one
    cfg_reg_bank #(
        .bank_code (BANK_CORE_RD),
        .num_words (CORE_RD_WORDS)
    ) u_core_rd_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .words     (core_rd_words)
    );

    cfg_reg_bank #(
        .bank_code (BANK_DMA_RD),
        .num_words (DMA_RD_WORDS)
    ) u_dma_rd_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .words     (dma_rd_words)
    );

    core_rd_field_decode #(
        .node_id (node_id)
    ) u_core_rd_decode (
        .words           (core_rd_words),
        .cr_mc           (cr_mc),
        .cr_dma_transfer (cr_dma_transfer),
        .cr_pingpong_en  (cr_pingpong_en),
        .cr_target_id    (cr_target_id),
        .cr_local_access (cr_local_access),
        .cr_base_addr    (cr_base_addr),
        .cr_pingpong_num (cr_pingpong_num),
        .cr_ping_len     (cr_ping_len),
        .cr_pong_len     (cr_pong_len)
    );

    dma_rd_field_decode #(
        .node_id (node_id)
    ) u_dma_rd_decode (
        .words            (dma_rd_words),
        .dr_dma_transfer  (dr_dma_transfer),
        .dr_pingpong_en   (dr_pingpong_en),
        .dr_ram_base_addr (dr_ram_base_addr),
        .dr_noc_base_addr (dr_noc_base_addr),
        .dr_pingpong_num  (dr_pingpong_num),
        .dr_ping_len      (dr_ping_len)
    );

    // finish grant comes back from the tracker
    cmd_dispatch u_cmd_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_addr     (cmd_addr),
        .core_rd_gnt  (core_rd_gnt),
        .dma_rd_gnt   (dma_rd_gnt),
        .all_finished (all_finished),
        .core_rd_req  (core_rd_req),
        .dma_rd_req   (dma_rd_req),
        .cmd_gnt      (cmd_gnt),
        .cmd_ok       (cmd_ok)
    );

    finish_tracker u_finish_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_gnt      (cmd_gnt),
        .cmd_addr     (cmd_addr),
        .core_rd_done (core_rd_done),
        .dma_rd_done  (dma_rd_done),
        .all_finished (all_finished)
    );

endmodule

`default_nettype wire

// ==== files.f ====
itf_ctr_pkg.sv
cfg_reg_bank.sv
core_rd_field_decode.sv
dma_rd_field_decode.sv
cmd_dispatch.sv
finish_tracker.sv
dnoc_itf_ctr_top.sv
dnoc_itf_ctr_sva.sv
tb_dnoc_itf_ctr.sv

// ==== finish_tracker.sv ====
// finish_tracker: per-channel armed and done bits, all_finished level
`default_nettype none
`timescale 1ns/10ps

module finish_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_req,
    input  logic                   cmd_gnt,
    input  itf_ctr_pkg::cmd_code_t cmd_addr,
    input  logic                   core_rd_done,
    input  logic                   dma_rd_done,
    output logic                   all_finished
);

    import itf_ctr_pkg::*;

    // bit 0 core read, bit 1 dma read
    logic [NUM_CHAN-1:0] armed;
    logic [NUM_CHAN-1:0] done_bits;
    logic [NUM_CHAN-1:0] chan_hit;
    logic [NUM_CHAN-1:0] done_in;
    logic                accept;
    logic                finish_acc;

    assign accept     = cmd_req && cmd_gnt;
    assign finish_acc = accept && (cmd_addr == CMD_FINISH);

    assign chan_hit = {cmd_addr == CMD_DMA_RD, cmd_addr == CMD_CORE_RD};
    assign done_in  = {dma_rd_done, core_rd_done};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed     <= '0;
            done_bits <= '0;
        end else if (finish_acc) begin
            // query accepted, start over
            armed     <= '0;
            done_bits <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (accept && chan_hit[i]) begin
                    // new command, earlier done no longer counts
                    armed[i]     <= 1'b1;
                    done_bits[i] <= 1'b0;
                end else if (done_in[i]) begin
                    done_bits[i] <= 1'b1;
                end
            end
        end
    end

    // nothing armed after reset, so high
    assign all_finished = (done_bits == armed);

endmodule

`default_nettype wire

// ==== itf_ctr_pkg.sv ====
// widths, vector types, bank and command codes, register word indices, node offset function
`default_nettype none

package itf_ctr_pkg;

    // vector types with a meaning on the interface
    typedef logic [6:0]  cfg_addr_t;
    typedef logic [12:0] cfg_data_t;
    typedef logic [4:0]  word_idx_t;
    typedef logic [1:0]  bank_code_t;
    typedef logic [3:0]  node_id_t;
    // bit 4 set means minus
    typedef logic [4:0]  rel_addr_t;
    typedef logic [24:0] noc_addr_t;
    typedef logic [11:0] noc_high_t;
    typedef logic [12:0] ram_addr_t;
    typedef logic [10:0] pp_num_t;
    typedef logic [2:0]  cmd_code_t;

    // bank codes, upper two bits of cfg_addr
    localparam bank_code_t BANK_CORE_RD = 2'd0;
    localparam bank_code_t BANK_DMA_RD  = 2'd2;

    // command codes on cmd_addr
    localparam cmd_code_t CMD_CORE_RD = 3'd0;
    localparam cmd_code_t CMD_DMA_RD  = 3'd2;
    localparam cmd_code_t CMD_FINISH  = 3'd4;

    localparam int NUM_CHAN      = 2;
    localparam int CORE_RD_WORDS = 10;
    localparam int DMA_RD_WORDS  = 9;

    // core-read bank layout
    localparam int CR_ADDR_MODE     = 0;
    localparam int CR_REL_OFFSET    = 1;
    localparam int CR_MC            = 2;
    localparam int CR_DMA_TRANSFER  = 3;
    localparam int CR_PP_EN         = 4;
    localparam int CR_ABS_TARGET    = 5;
    localparam int CR_BASE_ADDR     = 6;
    localparam int CR_PP_NUM        = 7;
    localparam int CR_PING_LEN      = 8;
    localparam int CR_PONG_LEN      = 9;

    // dma-read bank layout
    localparam int DR_ADDR_MODE     = 0;
    localparam int DR_REL_OFFSET    = 1;
    localparam int DR_DMA_TRANSFER  = 2;
    localparam int DR_PP_EN         = 3;
    localparam int DR_RAM_BASE      = 4;
    localparam int DR_NOC_LOW       = 5;
    localparam int DR_NOC_HIGH      = 6;
    localparam int DR_PP_NUM        = 7;
    localparam int DR_PING_LEN      = 8;

    // node id plus or minus the low offset bits, wraps modulo 16
    function automatic node_id_t rel_node(node_id_t base, rel_addr_t offset);
        return offset[4] ? (base - offset[3:0]) : (base + offset[3:0]);
    endfunction

endpackage

`default_nettype wire

// ==== itf_ctr_trace.txt ====
# W addr data | F field expected | D core_done dma_done (all values hex)
# C code core_gnt dma_gnt exp_core_req exp_dma_req exp_gnt, cmd_ok checked one cycle later
F cmd_ok 0
F cr_target_id 0
F cr_local_access 0
F cr_base_addr 0
F cr_pingpong_num 0
F dr_ram_base_addr 0
F dr_noc_base_addr 0
C 4 0 0 0 0 1
W 05 0005
F cr_target_id 5
F cr_local_access 1
W 05 0006
F cr_target_id 6
F cr_local_access 0
W 01 0017
W 00 0001
F cr_target_id e
F cr_local_access 0
W 01 0000
F cr_target_id 5
F cr_local_access 1
W 02 0001
F cr_mc 1
F cr_local_access 0
W 26 1fff
W 66 1fff
W 0a 1fff
F cr_base_addr 0
F cr_pong_len 0
F dr_noc_base_addr 0
W 06 1abc
W 07 07ff
W 09 0123
F cr_base_addr 1abc
F cr_pingpong_num 7ff
F cr_pong_len 0123
W 46 0abc
W 45 1234
W 44 0777
F dr_noc_base_addr 1579234
F dr_ram_base_addr 0777
W 41 0003
W 40 0001
F dr_noc_base_addr 0011234
C 0 0 0 1 0 0
C 0 1 0 1 0 1
C 1 1 1 0 0 0
C 3 1 1 0 0 0
C 2 0 1 0 1 1
C 4 0 0 0 0 0
D 1 0
C 4 0 0 0 0 0
D 0 1
C 4 0 0 0 0 1
C 4 0 0 0 0 1

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_dnoc_itf_ctr -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "** PASS **" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb_dnoc_itf_ctr.sv ====
// testbench for dnoc_itf_ctr_top: clock, reset, trace replay, compare tasks, timeout, verdict
`timescale 1ns/10ps
`default_nettype none

module tb_dnoc_itf_ctr;

    import itf_ctr_pkg::*;

    localparam int CLK_PERIOD = 100;

    logic      clk;
    logic      rst_n;
    logic      cfg_valid;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
    logic      cmd_req;
    cmd_code_t cmd_addr;
    logic      cmd_gnt;
    logic      cmd_ok;
    logic      core_rd_req;
    logic      core_rd_gnt;
    logic      core_rd_done;
    logic      dma_rd_req;
    logic      dma_rd_gnt;
    logic      dma_rd_done;
    logic      cr_mc;
    logic      cr_dma_transfer;
    logic      cr_pingpong_en;
    node_id_t  cr_target_id;
    logic      cr_local_access;
    ram_addr_t cr_base_addr;
    pp_num_t   cr_pingpong_num;
    ram_addr_t cr_ping_len;
    ram_addr_t cr_pong_len;
    logic      dr_dma_transfer;
    logic      dr_pingpong_en;
    ram_addr_t dr_ram_base_addr;
    noc_addr_t dr_noc_base_addr;
    pp_num_t   dr_pingpong_num;
    ram_addr_t dr_ping_len;

    // raw trace lines, comments included
    string trace_lines [$];
    int    errors;
    int    timeouts;
    int    cycles;
    int    limit;

    dnoc_itf_ctr_top #(.node_id(4'd5)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic node_compare(input string name, input node_id_t exp, input node_id_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic noc_compare(input string name, input noc_addr_t exp, input noc_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic ram_compare(input string name, input ram_addr_t exp, input ram_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic pp_compare(input string name, input pp_num_t exp, input pp_num_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic bit_compare(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen("itf_ctr_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open itf_ctr_trace.txt, no stimulus was applied");
        end else begin
            while ($fgets(line, fd) > 0) begin
                trace_lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // words the trace file leaves at their reset value
    task automatic append_field_checks();
        trace_lines.push_back("W 03 0001");
        trace_lines.push_back("F cr_dma_transfer 1");
        trace_lines.push_back("F dr_dma_transfer 0");
        trace_lines.push_back("W 04 0001");
        trace_lines.push_back("F cr_pingpong_en 1");
        trace_lines.push_back("W 08 0456");
        trace_lines.push_back("F cr_ping_len 0456");
        trace_lines.push_back("W 42 0001");
        trace_lines.push_back("F dr_dma_transfer 1");
        trace_lines.push_back("W 43 0001");
        trace_lines.push_back("F dr_pingpong_en 1");
        // count keeps only the low 11 bits
        trace_lines.push_back("W 47 1555");
        trace_lines.push_back("F dr_pingpong_num 555");
        trace_lines.push_back("W 48 0abc");
        trace_lines.push_back("F dr_ping_len 0abc");
    endtask

    // one trace operation, entered and left on a falling edge
    task automatic run_line(input string line);
        string       op;
        string       fname;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        int          n;
        n = $sscanf(line, "%s", op);
        // blank line or comment
        if (n != 1 || op.getc(0) == "#") begin
            return;
        end
        case (op)
            "W": begin
                n = $sscanf(line, "%s %h %h", op, a, b);
                cfg_valid = 1'b1;
                cfg_addr  = cfg_addr_t'(a);
                cfg_data  = cfg_data_t'(b);
                @(negedge clk);
                cfg_valid = 1'b0;
            end
            "C": begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", op, a, b, c, d, e, f);
                cmd_req     = 1'b1;
                cmd_addr    = cmd_code_t'(a);
                core_rd_gnt = b[0];
                dma_rd_gnt  = c[0];
                // routing is combinational, look mid low phase
                #(CLK_PERIOD / 4);
                bit_compare("core_rd_req", d[0], core_rd_req);
                bit_compare("dma_rd_req", e[0], dma_rd_req);
                bit_compare("cmd_gnt", f[0], cmd_gnt);
                @(negedge clk);
                // cmd_ok one cycle behind the grant
                bit_compare("cmd_ok", f[0], cmd_ok);
                cmd_req     = 1'b0;
                cmd_addr    = CMD_CORE_RD;
                core_rd_gnt = 1'b0;
                dma_rd_gnt  = 1'b0;
            end
            "D": begin
                n = $sscanf(line, "%s %h %h", op, a, b);
                core_rd_done = a[0];
                dma_rd_done  = b[0];
                @(negedge clk);
                core_rd_done = 1'b0;
                dma_rd_done  = 1'b0;
            end
            "F": begin
                n = $sscanf(line, "%s %s %h", op, fname, a);
                case (fname)
                    "cmd_ok":           bit_compare(fname, a[0], cmd_ok);
                    "cr_mc":            bit_compare(fname, a[0], cr_mc);
                    "cr_dma_transfer":  bit_compare(fname, a[0], cr_dma_transfer);
                    "cr_pingpong_en":   bit_compare(fname, a[0], cr_pingpong_en);
                    "cr_local_access":  bit_compare(fname, a[0], cr_local_access);
                    "cr_target_id":     node_compare(fname, node_id_t'(a), cr_target_id);
                    "cr_base_addr":     ram_compare(fname, ram_addr_t'(a), cr_base_addr);
                    "cr_pingpong_num":  pp_compare(fname, pp_num_t'(a), cr_pingpong_num);
                    "cr_ping_len":      ram_compare(fname, ram_addr_t'(a), cr_ping_len);
                    "cr_pong_len":      ram_compare(fname, ram_addr_t'(a), cr_pong_len);
                    "dr_dma_transfer":  bit_compare(fname, a[0], dr_dma_transfer);
                    "dr_pingpong_en":   bit_compare(fname, a[0], dr_pingpong_en);
                    "dr_ram_base_addr": ram_compare(fname, ram_addr_t'(a), dr_ram_base_addr);
                    "dr_noc_base_addr": noc_compare(fname, noc_addr_t'(a), dr_noc_base_addr);
                    "dr_pingpong_num":  pp_compare(fname, pp_num_t'(a), dr_pingpong_num);
                    "dr_ping_len":      ram_compare(fname, ram_addr_t'(a), dr_ping_len);
                    default: begin
                        errors++;
                        $display("trace names an unknown field: %s", fname);
                    end
                endcase
            end
            default: begin
                errors++;
                $display("trace holds an unknown operation: %s", op);
            end
        endcase
    endtask

    initial begin
        errors       = 0;
        timeouts     = 0;
        limit        = 0;
        rst_n        = 1'b0;
        cfg_valid    = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        cmd_req      = 1'b0;
        cmd_addr     = CMD_CORE_RD;
        core_rd_gnt  = 1'b0;
        core_rd_done = 1'b0;
        dma_rd_gnt   = 1'b0;
        dma_rd_done  = 1'b0;
        load_trace();
        append_field_checks();
        // budget grows with the trace
        limit = 4 * trace_lines.size() + 40;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        foreach (trace_lines[i]) begin
            run_line(trace_lines[i]);
        end
        @(negedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog on rising edges
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        timeouts++;
        $display("timeout: trace did not finish within %0d cycles", limit);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
